/* hw/bp_pkg.sv */
package bp_pkg;

    typedef enum logic [2:0] {
        not_jump      = 3'd0,
        direct_jump   = 3'd1, // the only conditional kind
        ret           = 3'd4,
        indirect_jump = 3'd5,
        call          = 3'd6,
        jump          = 3'd7
    } branch_kind_t;

    // 2-bit saturating counter reset values
    localparam logic [1:0] weak_not_taken = 2'b01;
    localparam logic [1:0] strong_bimodal = 2'b00; // chooser takes gshare at 1x

    // fetch starts here
    localparam logic [29:0] reset_pc = 30'h0700_0000;

endpackage

/* hw/bp_update_if.sv */
`timescale 1ns/1ps

interface bp_update_if #(
    parameter int addr_width = 30
);
    import bp_pkg::*;

    logic                  update_en;
    logic [addr_width-1:0] pc_ex;
    branch_kind_t          kind_ex;
    logic                  taken_real;
    logic [addr_width-1:0] npc_ex;    // resolved target
    logic [addr_width-1:0] ret_pc_ex; // pushed on call

    modport source (
        output update_en, pc_ex, kind_ex, taken_real, npc_ex, ret_pc_ex
    );

    modport sink (
        input update_en, pc_ex, kind_ex, taken_real, npc_ex, ret_pc_ex
    );

endinterface

/* hw/kind_table.sv */
`timescale 1ns/1ps

module kind_table #(
    parameter int addr_width  = 30,
    parameter int index_width = 6
)(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic [addr_width-1:0] pc_reg,
    bp_update_if.sink             upd,
    output bp_pkg::branch_kind_t  kind_pdc
);
    import bp_pkg::*;

    localparam int entries = 2 ** index_width;

    branch_kind_t           kinds [entries];
    logic [index_width-1:0] rd_idx;
    logic [index_width-1:0] wr_idx;

    assign rd_idx = pc_reg[index_width-1:0];
    assign wr_idx = upd.pc_ex[index_width-1:0];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < entries; i++) begin
                kinds[i] <= not_jump;
            end
        end else if (upd.update_en) begin
            kinds[wr_idx] <= upd.kind_ex;
        end
    end

    // async read
    assign kind_pdc = kinds[rd_idx];

endmodule

/* hw/global_history.sv */
`timescale 1ns/1ps

module global_history #(
    parameter int ghr_width = 6
)(
    input  logic                 clk,
    input  logic                 rstn,
    bp_update_if.sink            upd,
    output logic [ghr_width-1:0] ghr
);
    import bp_pkg::*;

    logic shift_en;

    // committed conditional branches only
    assign shift_en = upd.update_en && (upd.kind_ex == direct_jump);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ghr <= '0;
        end else if (shift_en) begin
            ghr <= {ghr[ghr_width-2:0], upd.taken_real}; // newest at bit 0
        end
    end

endmodule

/* hw/direction_predictor.sv */
`timescale 1ns/1ps

module direction_predictor #(
    parameter int addr_width  = 30,
    parameter int index_width = 6,
    parameter int ghr_width   = 6
)(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic [addr_width-1:0] pc_reg,
    input  bp_pkg::branch_kind_t  kind_pdc,
    bp_update_if.sink             upd,
    output logic                  taken_pdc
);
    import bp_pkg::*;

    localparam int entries = 2 ** index_width;

    logic [1:0] bim [entries];
    logic [1:0] gsh [entries];
    logic [1:0] cho [entries];

    logic [ghr_width-1:0]   ghr;
    logic [index_width-1:0] ghr_ext;
    logic [index_width-1:0] bim_idx;
    logic [index_width-1:0] gsh_idx;
    logic [index_width-1:0] u_bim_idx;
    logic [index_width-1:0] u_gsh_idx;
    logic [1:0]             chosen;
    logic [1:0]             u_bim_ctr;
    logic [1:0]             u_gsh_ctr;
    logic                   train;

    function automatic logic [1:0] sat_step(input logic [1:0] ctr, input logic up);
        logic [1:0] res;
        res = ctr;
        if (up && ctr != 2'b11) begin
            res = ctr + 2'd1;
        end else if (!up && ctr != 2'b00) begin
            res = ctr - 2'd1;
        end
        return res;
    endfunction

    global_history #(.ghr_width(ghr_width)) u_ghr (
        .clk  (clk),
        .rstn (rstn),
        .upd  (upd),
        .ghr  (ghr)
    );

    assign ghr_ext = index_width'(ghr);

    // lookup
    assign bim_idx = pc_reg[index_width-1:0];
    assign gsh_idx = bim_idx ^ ghr_ext;
    assign chosen  = cho[bim_idx][1] ? gsh[gsh_idx] : bim[bim_idx];

    always_comb begin
        case (kind_pdc)
            not_jump:    taken_pdc = 1'b0;
            direct_jump: taken_pdc = chosen[1];
            default:     taken_pdc = 1'b1; // unconditional kinds
        endcase
    end

    // read-modify-write training with the current history
    assign train     = upd.update_en && (upd.kind_ex == direct_jump);
    assign u_bim_idx = upd.pc_ex[index_width-1:0];
    assign u_gsh_idx = u_bim_idx ^ ghr_ext;
    assign u_bim_ctr = bim[u_bim_idx];
    assign u_gsh_ctr = gsh[u_gsh_idx];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < entries; i++) begin
                bim[i] <= weak_not_taken;
                gsh[i] <= weak_not_taken;
                cho[i] <= strong_bimodal;
            end
        end else if (train) begin
            bim[u_bim_idx] <= sat_step(u_bim_ctr, upd.taken_real);
            gsh[u_gsh_idx] <= sat_step(u_gsh_ctr, upd.taken_real);
            if (u_bim_ctr[1] != u_gsh_ctr[1]) begin
                // step toward whichever was right
                cho[u_bim_idx] <= sat_step(cho[u_bim_idx], u_gsh_ctr[1] == upd.taken_real);
            end
        end
    end

endmodule

/* hw/target_predictor.sv */
`timescale 1ns/1ps

module target_predictor #(
    parameter int addr_width  = 30,
    parameter int index_width = 6,
    parameter int ras_depth   = 8
)(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic [addr_width-1:0] pc_reg,
    input  bp_pkg::branch_kind_t  kind_pdc,
    input  logic                  taken_pdc,
    bp_update_if.sink             upd,
    output logic [addr_width-1:0] npc_pdc
);
    import bp_pkg::*;

    localparam int entries   = 2 ** index_width;
    localparam int tag_width = addr_width - index_width;
    localparam int ptr_width = (ras_depth > 1) ? $clog2(ras_depth) : 1;
    localparam int cnt_width = $clog2(ras_depth + 1);
    localparam logic [ptr_width-1:0] last_slot = ptr_width'(ras_depth - 1);
    localparam logic [cnt_width-1:0] full_cnt  = cnt_width'(ras_depth);

    logic                  btb_valid  [entries];
    logic [tag_width-1:0]  btb_tag    [entries];
    logic [addr_width-1:0] btb_target [entries];
    logic [addr_width-1:0] ras        [ras_depth];

    logic [ptr_width-1:0]   ras_ptr; // next free slot
    logic [cnt_width-1:0]   ras_cnt;
    logic [ptr_width-1:0]   ras_top_idx;
    logic [ptr_width-1:0]   ras_next;
    logic [index_width-1:0] rd_idx;
    logic [index_width-1:0] wr_idx;
    logic                   btb_hit;
    logic                   btb_write;
    logic                   push;
    logic                   pop;

    assign rd_idx  = pc_reg[index_width-1:0];
    assign wr_idx  = upd.pc_ex[index_width-1:0];
    assign btb_hit = btb_valid[rd_idx] && (btb_tag[rd_idx] == pc_reg[addr_width-1:index_width]);

    assign btb_write = upd.update_en && upd.taken_real &&
                       (upd.kind_ex != not_jump) && (upd.kind_ex != ret);
    assign push = upd.update_en && (upd.kind_ex == call);
    assign pop  = upd.update_en && (upd.kind_ex == ret) && (ras_cnt != '0);

    assign ras_next    = (ras_ptr == last_slot) ? '0 : ras_ptr + 1'b1;
    assign ras_top_idx = (ras_ptr == '0) ? last_slot : ras_ptr - 1'b1;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ras_ptr <= '0;
            ras_cnt <= '0;
            for (int i = 0; i < entries; i++) begin
                btb_valid[i] <= 1'b0;
            end
        end else begin
            if (btb_write) begin
                btb_valid[wr_idx] <= 1'b1;
            end
            if (push) begin
                ras_ptr <= ras_next; // full stack overwrites oldest
                if (ras_cnt != full_cnt) begin
                    ras_cnt <= ras_cnt + 1'b1;
                end
            end else if (pop) begin
                ras_ptr <= ras_top_idx;
                ras_cnt <= ras_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (btb_write) begin
            btb_tag[wr_idx]    <= upd.pc_ex[addr_width-1:index_width];
            btb_target[wr_idx] <= upd.npc_ex;
        end
        if (push) begin
            ras[ras_ptr] <= upd.ret_pc_ex;
        end
    end

    always_comb begin
        npc_pdc = pc_reg + addr_width'(1);
        if (taken_pdc && (kind_pdc == ret) && (ras_cnt != '0)) begin
            npc_pdc = ras[ras_top_idx];
        end else if (taken_pdc && btb_hit) begin
            npc_pdc = btb_target[rd_idx];
        end
    end

endmodule

/* hw/branch_predictor.sv */
`timescale 1ns/1ps

module branch_predictor #(
    parameter int addr_width  = 30,
    parameter int index_width = 6,
    parameter int ghr_width   = 6, // keep <= index_width
    parameter int ras_depth   = 8
)(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic [addr_width-1:0] pc,
    input  logic                  stall,
    output bp_pkg::branch_kind_t  kind_pdc,
    output logic                  taken_pdc,
    output logic [addr_width-1:0] npc_pdc,
    input  logic                  update_en,
    input  logic [addr_width-1:0] pc_ex,
    input  bp_pkg::branch_kind_t  kind_ex,
    input  logic                  taken_real,
    input  logic [addr_width-1:0] npc_ex,
    input  logic [addr_width-1:0] ret_pc_ex
);
    import bp_pkg::*;

    logic [addr_width-1:0] pc_reg;

    bp_update_if #(.addr_width(addr_width)) upd_bus ();

    assign upd_bus.update_en  = update_en;
    assign upd_bus.pc_ex      = pc_ex;
    assign upd_bus.kind_ex    = kind_ex;
    assign upd_bus.taken_real = taken_real;
    assign upd_bus.npc_ex     = npc_ex;
    assign upd_bus.ret_pc_ex  = ret_pc_ex;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc_reg <= addr_width'(reset_pc);
        end else if (!stall) begin
            pc_reg <= pc;
        end
    end

    kind_table #(.addr_width(addr_width), .index_width(index_width)) u_kind (
        .clk      (clk),
        .rstn     (rstn),
        .pc_reg   (pc_reg),
        .upd      (upd_bus.sink),
        .kind_pdc (kind_pdc)
    );

    direction_predictor #(
        .addr_width  (addr_width),
        .index_width (index_width),
        .ghr_width   (ghr_width)
    ) u_dir (
        .clk       (clk),
        .rstn      (rstn),
        .pc_reg    (pc_reg),
        .kind_pdc  (kind_pdc),
        .upd       (upd_bus.sink),
        .taken_pdc (taken_pdc)
    );

    target_predictor #(
        .addr_width  (addr_width),
        .index_width (index_width),
        .ras_depth   (ras_depth)
    ) u_tgt (
        .clk       (clk),
        .rstn      (rstn),
        .pc_reg    (pc_reg),
        .kind_pdc  (kind_pdc),
        .taken_pdc (taken_pdc),
        .upd       (upd_bus.sink),
        .npc_pdc   (npc_pdc)
    );

endmodule

/* testbench/branch_predictor_props.sv */
`timescale 1ns/1ps

module branch_predictor_props #(
    parameter int addr_width = 30
)(
    input logic                  clk,
    input logic                  rstn,
    input logic                  stall,
    input logic [addr_width-1:0] pc_reg,
    input bp_pkg::branch_kind_t  kind_pdc,
    input logic                  taken_pdc,
    input logic [addr_width-1:0] npc_pdc
);
    import bp_pkg::*;

    int fail_count = 0;

    a_not_jump_not_taken: assert property (@(posedge clk) disable iff (!rstn)
        (kind_pdc == not_jump) |-> !taken_pdc)
    else begin
        $error("taken predicted for a not_jump kind");
        fail_count++;
    end

    a_not_taken_next: assert property (@(posedge clk) disable iff (!rstn)
        !taken_pdc |-> (npc_pdc == pc_reg + addr_width'(1)))
    else begin
        $error("not-taken prediction is not pc plus one");
        fail_count++;
    end

    a_stall_hold: assert property (@(posedge clk) disable iff (!rstn)
        stall |=> $stable(pc_reg))
    else begin
        $error("pc_reg moved while stalled");
        fail_count++;
    end

    a_kind_known: assert property (@(posedge clk) disable iff (!rstn)
        !$isunknown(kind_pdc))
    else begin
        $error("kind_pdc is unknown after reset");
        fail_count++;
    end

    // reset loads the fetch start address
    a_reset_pc: assert property (@(posedge clk)
        !rstn |=> (pc_reg == addr_width'(reset_pc)))
    else begin
        $error("pc_reg not at reset_pc after reset");
        fail_count++;
    end

endmodule

bind branch_predictor branch_predictor_props #(.addr_width(addr_width)) u_props (
    .clk       (clk),
    .rstn      (rstn),
    .stall     (stall),
    .pc_reg    (pc_reg),
    .kind_pdc  (kind_pdc),
    .taken_pdc (taken_pdc),
    .npc_pdc   (npc_pdc)
);

/* testbench/branch_predictor_tb.sv */
`timescale 1ns/1ps

module branch_predictor_tb;
    import bp_pkg::*;

    localparam int addr_width = 30;
    localparam int num_rows   = 20;
    localparam int period_ns  = 100;
    localparam int timeout_ns = 2 * num_rows * 4 * period_ns;

    logic                  clk;
    logic                  rstn;
    logic [addr_width-1:0] pc;
    logic                  stall;
    branch_kind_t          kind_pdc;
    logic                  taken_pdc;
    logic [addr_width-1:0] npc_pdc;
    logic                  update_en;
    logic [addr_width-1:0] pc_ex;
    branch_kind_t          kind_ex;
    logic                  taken_real;
    logic [addr_width-1:0] npc_ex;
    logic [addr_width-1:0] ret_pc_ex;

    // stimulus table with one entry per row
    string                 row_name  [num_rows];
    logic                  row_upd   [num_rows];
    logic                  row_stall [num_rows];
    logic [addr_width-1:0] row_pc    [num_rows];
    branch_kind_t          row_kind  [num_rows];
    logic                  row_taken [num_rows];
    logic [addr_width-1:0] row_npc   [num_rows];
    logic [addr_width-1:0] row_ret   [num_rows];
    branch_kind_t          exp_kind  [num_rows];
    logic                  exp_taken [num_rows];
    logic [addr_width-1:0] exp_npc   [num_rows];

    int n_rows  = 0;
    int applied = 0;
    int passed  = 0;
    int failed  = 0;

    branch_predictor #(.addr_width(addr_width)) uut (.*);

    always #(period_ns / 2) clk = ~clk;

    task automatic add_update(input string name, input logic [29:0] p, input branch_kind_t k,
                              input logic t, input logic [29:0] n, input logic [29:0] r);
        row_name[n_rows]  = name;
        row_upd[n_rows]   = 1'b1;
        row_stall[n_rows] = 1'b0;
        row_pc[n_rows]    = p;
        row_kind[n_rows]  = k;
        row_taken[n_rows] = t;
        row_npc[n_rows]   = n;
        row_ret[n_rows]   = r;
        n_rows++;
    endtask

    task automatic add_predict(input string name, input logic [29:0] p, input logic s,
                               input branch_kind_t ek, input logic et, input logic [29:0] en);
        row_name[n_rows]  = name;
        row_upd[n_rows]   = 1'b0;
        row_stall[n_rows] = s;
        row_pc[n_rows]    = p;
        exp_kind[n_rows]  = ek;
        exp_taken[n_rows] = et;
        exp_npc[n_rows]   = en;
        n_rows++;
    endtask

    task automatic build_table(input logic [29:0] rnd_pc);
        add_predict("reset_random", rnd_pc, 1'b0, not_jump, 1'b0, rnd_pc + 30'd1);
        add_update("dj_taken_1", 30'h0000_1010, direct_jump, 1'b1, 30'h0000_2000, '0);
        add_update("dj_taken_2", 30'h0000_1010, direct_jump, 1'b1, 30'h0000_2000, '0);
        add_predict("dj_pred_taken", 30'h0000_1010, 1'b0, direct_jump, 1'b1, 30'h0000_2000);
        add_update("dj_not_taken_1", 30'h0000_1010, direct_jump, 1'b0, 30'h0000_1011, '0);
        add_update("dj_not_taken_2", 30'h0000_1010, direct_jump, 1'b0, 30'h0000_1011, '0);
        add_predict("dj_pred_not_taken", 30'h0000_1010, 1'b0, direct_jump, 1'b0, 30'h0000_1011);
        add_update("jump_write", 30'h0000_3025, jump, 1'b1, 30'h0000_4444, '0);
        add_predict("jump_pred", 30'h0000_3025, 1'b0, jump, 1'b1, 30'h0000_4444);
        add_predict("jump_tag_miss", 30'h0000_7025, 1'b0, jump, 1'b1, 30'h0000_7026);
        add_update("ret_empty_pop", 30'h0000_5230, ret, 1'b1, '0, '0); // only sets the kind
        add_update("call_a", 30'h0000_5008, call, 1'b1, 30'h0000_6000, 30'h0000_5009);
        add_update("call_b", 30'h0000_510a, call, 1'b1, 30'h0000_6100, 30'h0000_510b);
        add_predict("ret_pred_b", 30'h0000_5230, 1'b0, ret, 1'b1, 30'h0000_510b);
        add_update("ret_pop_b", 30'h0000_5230, ret, 1'b1, '0, '0);
        add_predict("ret_pred_a", 30'h0000_5230, 1'b0, ret, 1'b1, 30'h0000_5009);
        add_update("ret_pop_a", 30'h0000_5230, ret, 1'b1, '0, '0);
        add_predict("ret_pred_empty", 30'h0000_5230, 1'b0, ret, 1'b1, 30'h0000_5231);
        add_predict("stall_hold", 30'h0000_0001, 1'b1, ret, 1'b1, 30'h0000_5231);
        add_predict("stall_release", 30'h0000_0001, 1'b0, not_jump, 1'b0, 30'h0000_0002);
    endtask

    task automatic apply_update(input int i);
        @(posedge clk);
        update_en  <= 1'b1;
        pc_ex      <= row_pc[i];
        kind_ex    <= row_kind[i];
        taken_real <= row_taken[i];
        npc_ex     <= row_npc[i];
        ret_pc_ex  <= row_ret[i];
        @(posedge clk);
        update_en  <= 1'b0; // one-cycle strobe
        $display("%s: update applied", row_name[i]);
        applied++;
    endtask

    task automatic apply_predict(input int i);
        int bad;
        bad = 0;
        @(posedge clk);
        pc    <= row_pc[i];
        stall <= row_stall[i];
        @(posedge clk); // pc sampled here
        @(negedge clk);
        assert (kind_pdc === exp_kind[i]) else begin
            $display("MISMATCH %s kind expected %0d actual %0d", row_name[i], exp_kind[i],
                     kind_pdc);
            bad++;
        end
        assert (taken_pdc === exp_taken[i]) else begin
            $display("MISMATCH %s taken expected %0b actual %0b", row_name[i], exp_taken[i],
                     taken_pdc);
            bad++;
        end
        assert (npc_pdc === exp_npc[i]) else begin
            $display("MISMATCH %s npc expected %h actual %h", row_name[i], exp_npc[i], npc_pdc);
            bad++;
        end
        if (bad == 0) begin
            $display("%s: ok", row_name[i]);
            passed++;
        end else begin
            $display("%s: %0d wrong outputs", row_name[i], bad);
            failed++;
        end
    endtask

    initial begin
        logic [29:0] rnd_pc;
        clk        = 1'b0;
        rstn       = 1'b0;
        pc         = '0;
        stall      = 1'b0;
        update_en  = 1'b0;
        pc_ex      = '0;
        kind_ex    = not_jump;
        taken_real = 1'b0;
        npc_ex     = '0;
        ret_pc_ex  = '0;
        void'($urandom(32'hffe5_efd5));
        rnd_pc = 30'($urandom());
        build_table(rnd_pc);
        repeat (10) @(posedge clk);
        rstn <= 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            if (row_upd[i]) begin
                apply_update(i);
            end else begin
                apply_predict(i);
            end
        end
        @(posedge clk);
        @(negedge clk);
        $display("%0d rows: %0d updates applied, %0d passed, %0d failed, %0d property failures",
                 n_rows, applied, passed, failed, uut.u_props.fail_count);
        if (failed == 0 && uut.u_props.fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(timeout_ns * 1ns);
        $display("timeout: the test rows did not finish in %0d ns", timeout_ns);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* all.f */
hw/bp_pkg.sv
hw/bp_update_if.sv
hw/kind_table.sv
hw/global_history.sv
hw/direction_predictor.sv
hw/target_predictor.sv
hw/branch_predictor.sv
testbench/branch_predictor_props.sv
testbench/branch_predictor_tb.sv
